// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f mem_subsys.f --top-module tb_mem_subsys -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: data_ram.sv
`timescale 1ns/10ps
`include "mem_subsys_settings.svh"

module data_ram (
        input  logic            clk,
        input  logic            rst,
        wb_bus_if.slave         bus
);

        localparam int IDX_W = $clog2(`MEM_SUBSYS_RAM_WORDS);

        logic [31:0]      mem [`MEM_SUBSYS_RAM_WORDS];
        logic [IDX_W-1:0] idx;
        logic [31:0]      rdata;
        logic             ack_q;
        logic             access;

        assign idx    = bus.adr[IDX_W+1:2];
        assign access = bus.cyc & bus.stb & ~ack_q;

        // one wait state, ack drops again after each transfer.
        always_ff @(posedge clk) begin
                if (rst) begin
                        ack_q <= 1'b0;
                end else begin
                        ack_q <= access;
                end
        end

        always_ff @(posedge clk) begin
                if (access) begin
                        rdata <= mem[idx];
                        for (int i = 0; i < 4; i++) begin
                                if (bus.we & bus.sel[i]) begin
                                        mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
                                end
                        end
                end
        end

        assign bus.ack   = ack_q;
        assign bus.dat_r = rdata;

endmodule

// File: inst_fetch_port.sv
`timescale 1ns/10ps
`include "mem_subsys_settings.svh"

module inst_fetch_port (
        input  logic            clk,
        input  logic            rst,
        input  logic            fetch_req,
        input  logic [31:0]     fetch_addr,
        wb_bus_if.master        bus,
        output logic            fetch_done,
        output logic [31:0]     fetch_inst
);

        logic        req_q;
        logic        busy;
        logic        start;
        logic        finish;
        logic [31:0] addr_q;

        // a new read starts only on a rising request.
        assign start  = fetch_req & ~req_q & ~busy;
        assign finish = busy & bus.ack;

        always_ff @(posedge clk) begin
                if (rst) begin
                        req_q      <= 1'b0;
                        busy       <= 1'b0;
                        fetch_done <= 1'b0;
                end else begin
                        req_q      <= fetch_req;
                        fetch_done <= finish;
                        if (finish) begin
                                busy <= 1'b0;
                        end else if (start) begin
                                busy <= 1'b1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (start) begin
                        addr_q <= fetch_addr;
                end
                if (finish) begin
                        fetch_inst <= bus.dat_r;
                end
        end

        assign bus.cyc   = busy;
        assign bus.stb   = busy;
        assign bus.we    = 1'b0;
        assign bus.sel   = 4'b1111;
        assign bus.adr   = {addr_q[`MEM_SUBSYS_ADDR_W-1:2], 2'b00};
        assign bus.dat_w = '0;

endmodule

// File: mem_access_stage.sv
`timescale 1ns/10ps
`include "mem_subsys_settings.svh"

module mem_access_stage
        import mem_subsys_pkg::*;
(
        input  logic            clk,
        input  logic            rst,
        input  logic            ex_valid,
        input  ex_to_mem_t      ex_rec,
        input  logic            flush,
        input  logic            wb_allowin,
        wb_bus_if.master        bus,
        output logic            ex_allowin,
        output logic            wb_valid,
        output mem_to_wb_t      wb_rec,
        output logic            fwd_valid,
        output logic [4:0]      fwd_rd,
        output logic [31:0]     fwd_data
);

        ex_to_mem_t  rec;
        logic        held;
        logic        done;
        logic        flushed;
        logic        kill;
        logic        take;
        logic        hand_on;
        logic        is_load;
        logic        is_store;
        logic        mem_req;
        logic [1:0]  lane;
        logic [3:0]  st_sel;
        logic [31:0] st_data;
        logic [31:0] ld_ext;
        logic [31:0] ld_data;

        assign is_load  = rec.op inside {op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w};
        assign is_store = rec.op inside {op_st_b, op_st_h, op_st_w};
        assign lane     = rec.alu_result[1:0];

        // ==================================================================
        // pipeline handshake
        // ==================================================================

        assign hand_on    = held & done & wb_allowin;
        assign ex_allowin = ~held | hand_on;
        assign take       = ex_valid & ex_allowin;
        assign kill       = flushed | flush;

        // done rises one cycle after an alu record is taken, or one cycle
        // after the ack of a memory record.
        always_ff @(posedge clk) begin
                if (rst) begin
                        held    <= 1'b0;
                        done    <= 1'b0;
                        flushed <= 1'b0;
                end else if (take) begin
                        held    <= 1'b1;
                        done    <= 1'b0;
                        flushed <= 1'b0;
                end else begin
                        if (hand_on) begin
                                held <= 1'b0;
                                done <= 1'b0;
                        end else if (held & ~done & (~(is_load | is_store) | bus.ack)) begin
                                done <= 1'b1;
                        end
                        if (held & flush) begin
                                flushed <= 1'b1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (take) begin
                        rec <= ex_rec;
                end
        end

        // ==================================================================
        // bus cycle, store lanes and load extension
        // ==================================================================

        // the request stays up from the cycle after the take until the
        // cycle after ack.
        assign mem_req = held & (is_load | is_store) & ~done;

        assign bus.cyc   = mem_req;
        assign bus.stb   = mem_req;
        assign bus.we    = is_store;
        assign bus.sel   = st_sel;
        assign bus.adr   = {rec.alu_result[`MEM_SUBSYS_ADDR_W-1:2], 2'b00};
        assign bus.dat_w = st_data;

        always_comb begin
                case (rec.op)
                op_st_b: begin
                        st_sel  = 4'b0001 << lane;
                        st_data = {4{rec.store_data[7:0]}};
                end
                op_st_h: begin
                        st_sel  = lane[1] ? 4'b1100 : 4'b0011;
                        st_data = {2{rec.store_data[15:0]}};
                end
                default: begin
                        st_sel  = 4'b1111;
                        st_data = rec.store_data;
                end
                endcase
        end

        always_comb begin
                logic [7:0]  rd_byte;
                logic [15:0] rd_half;

                rd_byte = bus.dat_r[8*lane +: 8];
                rd_half = lane[1] ? bus.dat_r[31:16] : bus.dat_r[15:0];
                case (rec.op)
                op_ld_b:  ld_ext = {{24{rd_byte[7]}}, rd_byte};
                op_ld_bu: ld_ext = {24'b0, rd_byte};
                op_ld_h:  ld_ext = {{16{rd_half[15]}}, rd_half};
                op_ld_hu: ld_ext = {16'b0, rd_half};
                default:  ld_ext = bus.dat_r;
                endcase
        end

        // read data is only on the bus during the ack cycle.
        always_ff @(posedge clk) begin
                if (bus.ack) begin
                        ld_data <= ld_ext;
                end
        end

        // ==================================================================
        // output register and forwarding
        // ==================================================================

        always_ff @(posedge clk) begin
                if (rst) begin
                        wb_valid <= 1'b0;
                end else if (wb_allowin) begin
                        wb_valid <= held & done & ~kill;
                end
        end

        always_ff @(posedge clk) begin
                if (hand_on) begin
                        wb_rec.pc    <= rec.pc;
                        wb_rec.gr_we <= rec.gr_we;
                        wb_rec.rd    <= rec.rd;
                        wb_rec.wdata <= is_load ? ld_data : rec.alu_result;
                end
        end

        assign fwd_valid = held & ~flushed & (rec.op == op_alu) & rec.gr_we;
        assign fwd_rd    = rec.rd;
        assign fwd_data  = rec.alu_result;

endmodule

// File: mem_subsys.f
+incdir+.
mem_subsys_pkg.sv
wb_bus_if.sv
mem_access_stage.sv
inst_fetch_port.sv
wb_arbiter.sv
data_ram.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// File: mem_subsys_pkg.sv
package mem_subsys_pkg;

        // ==================================================================
        // operation kinds seen by the memory-access stage
        // ==================================================================
        typedef enum logic [3:0] {
                op_alu,
                op_ld_b,
                op_ld_bu,
                op_ld_h,
                op_ld_hu,
                op_ld_w,
                op_st_b,
                op_st_h,
                op_st_w
        } mem_op_e;

        typedef enum logic [1:0] {
                idle,
                own_0,
                own_1
        } arb_state_e;

        // record handed over by the execute stage.
        // alu_result doubles as the byte address of a load or store.
        typedef struct packed {
                logic [31:0] pc;
                mem_op_e     op;
                logic        gr_we;
                logic [4:0]  rd;
                logic [31:0] alu_result;
                logic [31:0] store_data;
        } ex_to_mem_t;

        typedef struct packed {
                logic [31:0] pc;
                logic        gr_we;
                logic [4:0]  rd;
                logic [31:0] wdata;
        } mem_to_wb_t;

endpackage

// File: mem_subsys_settings.svh
`ifndef MEM_SUBSYS_SETTINGS_SVH
`define MEM_SUBSYS_SETTINGS_SVH

// ==========================================================================
// memory subsystem settings
// ==========================================================================

// byte address width on every wishbone bus.
`define MEM_SUBSYS_ADDR_W 32

// depth of the data RAM in 32-bit words.
`define MEM_SUBSYS_RAM_WORDS 256

// master that wins the first tie after reset, 0 or 1.
`define MEM_SUBSYS_RR_START 0

`endif

// File: mem_subsys_top.sv
`timescale 1ns/10ps

module mem_subsys_top
        import mem_subsys_pkg::*;
(
        input  logic            clk,
        input  logic            rst,
        input  logic            ex_valid,
        input  logic [31:0]     ex_pc,
        input  mem_op_e         ex_op,
        input  logic            ex_gr_we,
        input  logic [4:0]      ex_rd,
        input  logic [31:0]     ex_addr,
        input  logic [31:0]     ex_store_data,
        input  logic            flush,
        output logic            ex_allowin,
        input  logic            wb_allowin,
        output logic            wb_valid,
        output logic [31:0]     wb_pc,
        output logic            wb_gr_we,
        output logic [4:0]      wb_rd,
        output logic [31:0]     wb_wdata,
        output logic            fwd_valid,
        output logic [4:0]      fwd_rd,
        output logic [31:0]     fwd_data,
        input  logic            fetch_req,
        input  logic [31:0]     fetch_addr,
        output logic            fetch_done,
        output logic [31:0]     fetch_inst
);

        ex_to_mem_t ex_rec;
        mem_to_wb_t wb_rec;

        wb_bus_if m0_bus ();
        wb_bus_if m1_bus ();
        wb_bus_if s_bus ();

        // ==================================================================
        // record packing
        // ==================================================================

        assign ex_rec = '{
                pc:         ex_pc,
                op:         ex_op,
                gr_we:      ex_gr_we,
                rd:         ex_rd,
                alu_result: ex_addr,
                store_data: ex_store_data
        };

        assign wb_pc    = wb_rec.pc;
        assign wb_gr_we = wb_rec.gr_we;
        assign wb_rd    = wb_rec.rd;
        assign wb_wdata = wb_rec.wdata;

        // ==================================================================
        // bus masters, arbiter and RAM
        // ==================================================================

        mem_access_stage i_mem_stage (
                .clk        (clk),
                .rst        (rst),
                .ex_valid   (ex_valid),
                .ex_rec     (ex_rec),
                .flush      (flush),
                .wb_allowin (wb_allowin),
                .bus        (m0_bus),
                .ex_allowin (ex_allowin),
                .wb_valid   (wb_valid),
                .wb_rec     (wb_rec),
                .fwd_valid  (fwd_valid),
                .fwd_rd     (fwd_rd),
                .fwd_data   (fwd_data)
        );

        inst_fetch_port i_fetch (
                .clk        (clk),
                .rst        (rst),
                .fetch_req  (fetch_req),
                .fetch_addr (fetch_addr),
                .bus        (m1_bus),
                .fetch_done (fetch_done),
                .fetch_inst (fetch_inst)
        );

        wb_arbiter i_arbiter (
                .clk (clk),
                .rst (rst),
                .m0  (m0_bus),
                .m1  (m1_bus),
                .s   (s_bus)
        );

        data_ram i_ram (
                .clk (clk),
                .rst (rst),
                .bus (s_bus)
        );

endmodule

// File: mem_subsys_vectors.txt
// kind_op_address_storedata_rd_flush_expected; kind 1 is an execute record, 2 a fetch.
// op 0 alu, 1 ld_b, 2 ld_bu, 3 ld_h, 4 ld_hu, 5 ld_w, 6 st_b, 7 st_h, 8 st_w.
1_8_00000040_8899aabb_00_0_00000040
1_5_00000040_00000000_01_0_8899aabb
1_6_00000041_000000f1_00_0_00000041
1_1_00000041_00000000_02_0_fffffff1
1_2_00000041_00000000_03_0_000000f1
1_1_00000040_00000000_04_0_ffffffbb
1_6_00000043_00000012_00_0_00000043
1_2_00000043_00000000_05_0_00000012
1_1_00000042_00000000_06_0_ffffff99
1_6_00000042_00000034_00_0_00000042
1_3_00000042_00000000_07_0_00001234
1_4_00000040_00000000_08_0_0000f1bb
1_3_00000040_00000000_09_0_fffff1bb
1_6_00000040_0000007f_00_0_00000040
1_1_00000040_00000000_0a_0_0000007f
1_7_00000042_0000c3d4_00_0_00000042
1_3_00000042_00000000_0b_0_ffffc3d4
1_4_00000042_00000000_0c_0_0000c3d4
1_7_00000040_00005a6b_00_0_00000040
1_5_00000040_00000000_0d_0_c3d45a6b
1_3_00000040_00000000_0e_0_00005a6b
1_8_00000080_13579bdf_00_0_00000080
2_0_00000080_00000000_00_0_13579bdf
1_0_12345678_00000000_0f_0_12345678
1_0_cafe0001_00000000_10_0_cafe0001
1_8_00000084_02468ace_00_0_00000084
2_0_00000084_00000000_00_0_02468ace
2_0_00000040_00000000_00_0_c3d45a6b
1_8_00000044_deadbeef_00_1_00000000
1_5_00000044_00000000_11_0_deadbeef
1_2_00000047_00000000_12_0_000000de
1_5_00000044_00000000_13_1_00000000
1_0_00000055_00000000_14_1_00000000
1_0_00000777_00000000_15_0_00000777
2_0_00000044_00000000_00_0_deadbeef
1_1_00000046_00000000_16_0_ffffffad

// File: tb_mem_subsys.sv
`timescale 1ns/10ps

module tb_mem_subsys
        import mem_subsys_pkg::*;
();

        localparam int MAX_VECTORS = 64;
        localparam int WAIT_LIMIT  = 400;
        localparam logic [3:0] KIND_FETCH = 4'h2;

        // one line of the vector file, first column in the top bits.
        typedef struct packed {
                logic [3:0]  kind;
                logic [3:0]  op;
                logic [31:0] addr;
                logic [31:0] data;
                logic [7:0]  rd;
                logic [3:0]  flush;
                logic [31:0] exp_val;
        } vector_t;

        logic        clk = 1'b0;
        logic        rst;
        logic        ex_valid;
        logic [31:0] ex_pc;
        mem_op_e     ex_op;
        logic        ex_gr_we;
        logic [4:0]  ex_rd;
        logic [31:0] ex_addr;
        logic [31:0] ex_store_data;
        logic        flush;
        logic        ex_allowin;
        logic        wb_allowin;
        logic        wb_valid;
        logic [31:0] wb_pc;
        logic        wb_gr_we;
        logic [4:0]  wb_rd;
        logic [31:0] wb_wdata;
        logic        fwd_valid;
        logic [4:0]  fwd_rd;
        logic [31:0] fwd_data;
        logic        fetch_req;
        logic [31:0] fetch_addr;
        logic        fetch_done;
        logic [31:0] fetch_inst;

        logic [115:0] raw [MAX_VECTORS];
        bit           test_ok [MAX_VECTORS];
        int           n_vec;
        int           pass_count;
        int           fail_count;
        bit           reset_ok;
        bit           hold_ok;
        bit           fetch_busy;
        int           expected_wb [$];
        int           fetch_jobs [$];
        logic [16:0]  launch_lfsr;
        logic [16:0]  bp_lfsr;

        mem_subsys_top i_dut (
                .clk           (clk),
                .rst           (rst),
                .ex_valid      (ex_valid),
                .ex_pc         (ex_pc),
                .ex_op         (ex_op),
                .ex_gr_we      (ex_gr_we),
                .ex_rd         (ex_rd),
                .ex_addr       (ex_addr),
                .ex_store_data (ex_store_data),
                .flush         (flush),
                .ex_allowin    (ex_allowin),
                .wb_allowin    (wb_allowin),
                .wb_valid      (wb_valid),
                .wb_pc         (wb_pc),
                .wb_gr_we      (wb_gr_we),
                .wb_rd         (wb_rd),
                .wb_wdata      (wb_wdata),
                .fwd_valid     (fwd_valid),
                .fwd_rd        (fwd_rd),
                .fwd_data      (fwd_data),
                .fetch_req     (fetch_req),
                .fetch_addr    (fetch_addr),
                .fetch_done    (fetch_done),
                .fetch_inst    (fetch_inst)
        );

        always #10 clk = ~clk;

        // ==========================================================================
        // helpers
        // ==========================================================================

        // 17-bit fibonacci LFSR with taps 17 and 14, the new bit enters at bit 0.
        function automatic logic [16:0] lfsr_next(input logic [16:0] s);
                return {s[15:0], s[16] ^ s[13]};
        endfunction

        function automatic logic [31:0] pc_of(input int idx);
                return 32'h0000_1000 + idx * 4;
        endfunction

        // alu results and loads write a register, stores do not.
        function automatic logic gr_we_of(input logic [3:0] op);
                return op < 4'd6;
        endfunction

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp, inout bit ok);
                if (got !== exp) begin
                        $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
                        ok = 1'b0;
                end
        endtask

        task automatic finish_test(input string label, input bit ok);
                $display("test %s: %s", label, ok ? "pass" : "fail");
                if (ok) begin
                        pass_count++;
                end else begin
                        fail_count++;
                end
        endtask

        task automatic report_timeout(input string what);
                $display("timeout: %s", what);
                $display("Test failed");
                $finish;
        endtask

        // presents one execute record, waits for the take and pulses flush if asked.
        task automatic run_exec(input int idx);
                vector_t v;
                int      waited;
                bit      is_alu;

                v      = raw[idx];
                is_alu = (v.op == 4'd0);
                ex_valid      <= 1'b1;
                ex_pc         <= pc_of(idx);
                ex_op         <= mem_op_e'(v.op);
                ex_gr_we      <= gr_we_of(v.op);
                ex_rd         <= v.rd[4:0];
                ex_addr       <= v.addr;
                ex_store_data <= v.data;
                if (v.flush == 4'd0) begin
                        expected_wb.push_back(idx);
                end
                waited = 0;
                do begin
                        @(negedge clk);
                        waited++;
                        if (waited > WAIT_LIMIT) begin
                                report_timeout("the stage did not take an execute record");
                        end
                end while (!ex_allowin);
                @(posedge clk);
                ex_valid <= 1'b0;
                flush    <= (v.flush != 4'd0);
                @(negedge clk);
                check_value("fwd_valid", {31'b0, fwd_valid}, {31'b0, is_alu}, test_ok[idx]);
                if (is_alu) begin
                        check_value("fwd_rd", {27'b0, fwd_rd}, {27'b0, v.rd[4:0]}, test_ok[idx]);
                        check_value("fwd_data", fwd_data, v.addr, test_ok[idx]);
                end
                @(posedge clk);
                flush <= 1'b0;
                if (v.flush != 4'd0) begin
                        finish_test($sformatf("%0d flushed", idx), test_ok[idx]);
                end
        endtask

        // ==========================================================================
        // execute stream
        // ==========================================================================

        initial begin
                vector_t v;
                int      waited;

                rst           = 1'b1;
                ex_valid      = 1'b0;
                ex_pc         = '0;
                ex_op         = op_alu;
                ex_gr_we      = 1'b0;
                ex_rd         = '0;
                ex_addr       = '0;
                ex_store_data = '0;
                flush         = 1'b0;
                pass_count    = 0;
                fail_count    = 0;
                reset_ok      = 1'b1;
                hold_ok       = 1'b1;
                fetch_busy    = 1'b0;
                launch_lfsr   = 17'd79592;
                for (int i = 0; i < MAX_VECTORS; i++) begin
                        raw[i]     = '0;
                        test_ok[i] = 1'b1;
                end
                $readmemh("mem_subsys_vectors.txt", raw);
                n_vec = 0;
                while (n_vec < MAX_VECTORS && raw[n_vec][115:112] != 4'd0) begin
                        n_vec++;
                end
                if (n_vec == 0) begin
                        $display("no vectors were read from mem_subsys_vectors.txt");
                        fail_count++;
                end

                repeat (10) @(posedge clk);
                rst <= 1'b0;
                for (int i = 0; i < 4; i++) begin
                        @(negedge clk);
                        check_value("wb_valid", {31'b0, wb_valid}, 32'd0, reset_ok);
                        check_value("fwd_valid", {31'b0, fwd_valid}, 32'd0, reset_ok);
                        check_value("fetch_done", {31'b0, fetch_done}, 32'd0, reset_ok);
                        check_value("ex_allowin", {31'b0, ex_allowin}, 32'd1, reset_ok);
                end
                finish_test("reset", reset_ok);
                @(posedge clk);

                for (int i = 0; i < n_vec; i++) begin
                        v = raw[i];
                        if (v.kind == KIND_FETCH) begin
                                fetch_jobs.push_back(i);
                                launch_lfsr = lfsr_next(launch_lfsr);
                                // with a zero bit the fetch runs alone.
                                if (!launch_lfsr[0]) begin
                                        waited = 0;
                                        do begin
                                                @(negedge clk);
                                                waited++;
                                                if (waited > WAIT_LIMIT) begin
                                                        report_timeout("a fetch never finished");
                                                end
                                        end while (fetch_busy || fetch_jobs.size() != 0);
                                        @(posedge clk);
                                end
                        end else begin
                                run_exec(i);
                        end
                end

                waited = 0;
                while (expected_wb.size() != 0 || fetch_busy || fetch_jobs.size() != 0) begin
                        @(negedge clk);
                        waited++;
                        if (waited > WAIT_LIMIT) begin
                                report_timeout("writebacks or fetches were still missing");
                        end
                end
                finish_test("back-pressure hold", hold_ok);
                $display("tests passed %0d, failed %0d", pass_count, fail_count);
                if (fail_count == 0) begin
                        $display("Test completed successfully");
                end else begin
                        $display("Test failed");
                end
                $finish;
        end

        // ==========================================================================
        // back-pressure, fetch port and writeback collector
        // ==========================================================================

        initial begin
                wb_allowin = 1'b1;
                bp_lfsr    = 17'd79592;
                forever begin
                        @(posedge clk);
                        if (!rst) begin
                                bp_lfsr = lfsr_next(bp_lfsr);
                                wb_allowin <= bp_lfsr[0];
                        end
                end
        end

        initial begin
                int      idx;
                int      waited;
                vector_t v;

                fetch_req  = 1'b0;
                fetch_addr = '0;
                forever begin
                        @(posedge clk);
                        if (fetch_jobs.size() != 0) begin
                                idx        = fetch_jobs.pop_front();
                                v          = raw[idx];
                                fetch_busy = 1'b1;
                                fetch_req  <= 1'b1;
                                fetch_addr <= v.addr;
                                waited = 0;
                                do begin
                                        @(negedge clk);
                                        waited++;
                                        if (waited > WAIT_LIMIT) begin
                                                report_timeout("fetch_done never came");
                                        end
                                end while (!fetch_done);
                                check_value("fetch_inst", fetch_inst, v.exp_val, test_ok[idx]);
                                finish_test($sformatf("%0d fetch", idx), test_ok[idx]);
                                @(posedge clk);
                                fetch_req  <= 1'b0;
                                fetch_busy = 1'b0;
                        end
                end
        end

        // a result moves on at the rising edge after a cycle with valid and allowin.
        initial begin
                int          idx;
                vector_t     v;
                bit          holding;
                logic [31:0] held_pc;
                logic        held_gr_we;
                logic [4:0]  held_rd;
                logic [31:0] held_wdata;

                holding = 1'b0;
                forever begin
                        @(negedge clk);
                        if (holding) begin
                                check_value("wb_pc", wb_pc, held_pc, hold_ok);
                                check_value("wb_gr_we", {31'b0, wb_gr_we}, {31'b0, held_gr_we},
                                            hold_ok);
                                check_value("wb_rd", {27'b0, wb_rd}, {27'b0, held_rd}, hold_ok);
                                check_value("wb_wdata", wb_wdata, held_wdata, hold_ok);
                        end
                        holding    = wb_valid & ~wb_allowin;
                        held_pc    = wb_pc;
                        held_gr_we = wb_gr_we;
                        held_rd    = wb_rd;
                        held_wdata = wb_wdata;
                        if (wb_valid & wb_allowin) begin
                                if (expected_wb.size() == 0) begin
                                        $display("a writeback arrived with no record pending");
                                        fail_count++;
                                end else begin
                                        idx = expected_wb.pop_front();
                                        v   = raw[idx];
                                        check_value("wb_pc", wb_pc, pc_of(idx), test_ok[idx]);
                                        check_value("wb_gr_we", {31'b0, wb_gr_we},
                                                    {31'b0, gr_we_of(v.op)}, test_ok[idx]);
                                        check_value("wb_rd", {27'b0, wb_rd}, {27'b0, v.rd[4:0]},
                                                    test_ok[idx]);
                                        check_value("wb_wdata", wb_wdata, v.exp_val, test_ok[idx]);
                                        finish_test($sformatf("%0d writeback", idx), test_ok[idx]);
                                end
                        end
                end
        end

endmodule

// File: wb_arbiter.sv
`timescale 1ns/10ps
`include "mem_subsys_settings.svh"

module wb_arbiter
        import mem_subsys_pkg::*;
(
        input  logic            clk,
        input  logic            rst,
        wb_bus_if.slave         m0,
        wb_bus_if.slave         m1,
        wb_bus_if.master        s
);

        arb_state_e state;
        logic       last_owner;
        logic       owner;

        // in idle the grant is combinational, a tie goes to the master
        // that did not own the bus last.
        always_comb begin
                case (state)
                own_0:   owner = 1'b0;
                own_1:   owner = 1'b1;
                default: owner = m1.cyc & (~m0.cyc | ~last_owner);
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state      <= idle;
                        last_owner <= (`MEM_SUBSYS_RR_START != 0) ? 1'b0 : 1'b1;
                end else begin
                        case (state)
                        idle: begin
                                if (m0.cyc | m1.cyc) begin
                                        state      <= owner ? own_1 : own_0;
                                        last_owner <= owner;
                                end
                        end
                        own_0: if (~m0.cyc) state <= idle;
                        own_1: if (~m1.cyc) state <= idle;
                        default: state <= idle;
                        endcase
                end
        end

        assign s.cyc   = owner ? m1.cyc   : m0.cyc;
        assign s.stb   = owner ? m1.stb   : m0.stb;
        assign s.we    = owner ? m1.we    : m0.we;
        assign s.sel   = owner ? m1.sel   : m0.sel;
        assign s.adr   = owner ? m1.adr   : m0.adr;
        assign s.dat_w = owner ? m1.dat_w : m0.dat_w;

        assign m0.ack   = ~owner & s.ack;
        assign m1.ack   = owner & s.ack;
        assign m0.dat_r = owner ? '0 : s.dat_r;
        assign m1.dat_r = owner ? s.dat_r : '0;

endmodule

// File: wb_bus_if.sv
`timescale 1ns/10ps
`include "mem_subsys_settings.svh"

// wishbone classic bus, one master and one slave per instance.
interface wb_bus_if;

        logic                          cyc;
        logic                          stb;
        logic                          we;
        logic [3:0]                    sel;
        logic [`MEM_SUBSYS_ADDR_W-1:0] adr;
        logic [31:0]                   dat_w;
        logic [31:0]                   dat_r;
        logic                          ack;

        modport master (
                output cyc, stb, we, sel, adr, dat_w,
                input  dat_r, ack
        );

        modport slave (
                input  cyc, stb, we, sel, adr, dat_w,
                output dat_r, ack
        );

endinterface
